// ==== rtl/rab_axi_pkg.sv ====
/* AXI4-Lite bus definitions for the RAB configuration port.
   Only 64-bit data with 32-bit addresses is supported; every response is OKAY. */

package rab_axi_pkg;

  localparam int unsigned AXI_ADDR_W = 32;
  localparam int unsigned AXI_DATA_W = 64;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // address payload, used for AW and AR alike
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb; // one bit per data byte
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

// ==== rtl/rab_cfg_pkg.sv ====
/* Register map and slot encodings of the RAB configuration space.
   The slot index field is 8 bits wide, so at most 256 L1 slots are addressable. */

package rab_cfg_pkg;

  // miss handling registers live below this byte address, L1 slots above
  localparam int unsigned CFG_SPACE_SIZE = 'h20;

  localparam logic [4:0] MH_ADDR_OFS = 5'h00; // head address, no pop
  localparam logic [4:0] MH_META_OFS = 5'h08; // meta and empty flag, pops
  localparam logic [4:0] MH_CTRL_OFS = 5'h0C;

  localparam int unsigned MH_EMPTY_BIT = 31; // empty flag in the meta read word

  localparam int unsigned VIRT_ADDR_W = 32;
  localparam int unsigned PHYS_ADDR_W = 40;
  localparam int unsigned N_FLAGS     = 4;
  localparam int unsigned MISS_META_W = 10;

  localparam int unsigned SLOT_IDX_W = 8;

  typedef enum logic [1:0] {
    SLOT_VIRT  = 2'b00,
    SLOT_PHYS  = 2'b10,
    SLOT_FLAGS = 2'b11
  } slot_kind_e;

  // every slot group of four holds two virtual addresses, one physical, one flags word
  function automatic slot_kind_e slot_kind_of(input logic [1:0] idx_lsb);
    case (idx_lsb)
      2'b10:   return SLOT_PHYS;
      2'b11:   return SLOT_FLAGS;
      default: return SLOT_VIRT;
    endcase
  endfunction

  typedef struct packed {
    logic [VIRT_ADDR_W-1:0] addr;
    logic [MISS_META_W-1:0] meta;
  } miss_entry_t;

  typedef struct packed {
    logic allow_multi_hit; // bit 1
    logic fifo_disable;    // bit 0
  } mh_ctrl_t;

  typedef struct packed {
    logic [rab_axi_pkg::AXI_ADDR_W-6:0] upper;
    logic [4:0]                         ofs;
  } mh_addr_t;

  typedef struct packed {
    logic [rab_axi_pkg::AXI_ADDR_W-SLOT_IDX_W-4:0] upper;
    logic [SLOT_IDX_W-1:0]                         slot;
    logic [2:0]                                    byte_ofs;
  } l1_addr_t;

  // one captured address, seen either as a miss register offset or as an L1 slot
  typedef union packed {
    mh_addr_t mh;
    l1_addr_t l1;
  } cfg_addr_u;

endpackage

// ==== rtl/axi_lite_cfg_port.sv ====
/* AXI4-Lite slave of the configuration space; one write and one read in flight.
   Writes to unmapped addresses are acknowledged and dropped, unmapped reads return zero. */

`timescale 1ns/1ns

module axi_lite_cfg_port #(
  parameter int unsigned N_REGS = 196
) (
  input  logic                                 Clk_CI,
  input  logic                                 Rst_RBI,

  input  rab_axi_pkg::axi_aw_t                 s_aw_i,
  input  logic                                 s_awvalid_i,
  output logic                                 s_awready_o,
  input  rab_axi_pkg::axi_w_t                  s_w_i,
  input  logic                                 s_wvalid_i,
  output logic                                 s_wready_o,
  output rab_axi_pkg::axi_b_t                  s_b_o,
  output logic                                 s_bvalid_o,
  input  logic                                 s_bready_i,
  input  rab_axi_pkg::axi_aw_t                 s_ar_i,
  input  logic                                 s_arvalid_i,
  output logic                                 s_arready_o,
  output rab_axi_pkg::axi_r_t                  s_r_o,
  output logic                                 s_rvalid_o,
  input  logic                                 s_rready_i,

  output logic                                 wr_o,
  output logic                                 l1_sel_o,
  output logic                                 mh_sel_o,
  output rab_cfg_pkg::cfg_addr_u               wr_addr_o,
  output rab_axi_pkg::axi_w_t                  wr_data_o,
  output rab_cfg_pkg::cfg_addr_u               rd_addr_o,
  output logic                                 rd_pop_o,
  input  logic [rab_axi_pkg::AXI_DATA_W-1:0]   l1_rdata_i,
  input  logic [rab_axi_pkg::AXI_DATA_W-1:0]   mh_rdata_i
);
  import rab_axi_pkg::*;
  import rab_cfg_pkg::*;

  // slots 0..3 overlap the miss register space
  localparam int unsigned FIRST_L1_SLOT = CFG_SPACE_SIZE / AXI_STRB_W;

  logic                  aw_done_q;
  logic                  w_done_q;
  logic                  ar_done_q;
  logic                  wr_q;
  logic                  bvalid_q;
  logic                  rvalid_q;
  cfg_addr_u             aw_q;
  cfg_addr_u             ar_q;
  axi_w_t                w_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic [AXI_DATA_W-1:0] rdata_sel;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic r_load;

  function automatic logic in_mh_space(input cfg_addr_u a);
    return a.mh.upper == '0;
  endfunction

  function automatic logic in_l1_space(input cfg_addr_u a);
    return (a.l1.upper == '0) && (a.l1.slot >= FIRST_L1_SLOT) && (a.l1.slot < N_REGS);
  endfunction

  assign s_awready_o = ~aw_done_q;
  assign s_wready_o  = ~w_done_q;
  assign s_arready_o = ~ar_done_q;

  assign aw_hs  = s_awvalid_i & s_awready_o;
  assign w_hs   = s_wvalid_i & s_wready_o;
  assign b_hs   = bvalid_q & s_bready_i;
  assign ar_hs  = s_arvalid_i & s_arready_o;
  assign r_hs   = rvalid_q & s_rready_i;
  assign r_load = ar_done_q & ~rvalid_q; // first cycle after AR

  // write sequencing, readies reopen only after B
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      wr_q      <= 1'b0;
      bvalid_q  <= 1'b0;
    end
    else
    begin
      // pulse once, in the cycle after the later of AW and W
      wr_q <= (aw_done_q | aw_hs) & (w_done_q | w_hs) & ~(aw_done_q & w_done_q);
      if (b_hs)
      begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        bvalid_q  <= 1'b0;
      end
      else
      begin
        aw_done_q <= aw_done_q | aw_hs;
        w_done_q  <= w_done_q | w_hs;
        if (wr_q)
          bvalid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      ar_done_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else if (r_hs)
    begin
      ar_done_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      if (ar_hs)
        ar_done_q <= 1'b1;
      if (r_load)
        rvalid_q <= 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      aw_q <= cfg_addr_u'(s_aw_i.addr);
    if (w_hs)
      w_q <= s_w_i;
    if (ar_hs)
      ar_q <= cfg_addr_u'(s_ar_i.addr);
    if (r_load)
      rdata_q <= rdata_sel; // frozen until rready
  end

  always_comb
  begin
    if (in_mh_space(ar_q))
      rdata_sel = mh_rdata_i;
    else if (in_l1_space(ar_q))
      rdata_sel = l1_rdata_i;
    else
      rdata_sel = '0;
  end

  assign wr_o      = wr_q;
  assign l1_sel_o  = in_l1_space(aw_q);
  assign mh_sel_o  = in_mh_space(aw_q);
  assign wr_addr_o = aw_q;
  assign wr_data_o = w_q;
  assign rd_addr_o = ar_q;

  // pop only the entry that was actually reported, a late push must survive
  assign rd_pop_o = r_hs & in_mh_space(ar_q) & (ar_q.mh.ofs == MH_META_OFS)
                    & ~rdata_q[MH_EMPTY_BIT];

  assign s_bvalid_o   = bvalid_q;
  assign s_b_o.resp   = RESP_OKAY;
  assign s_rvalid_o   = rvalid_q;
  assign s_r_o.data   = rdata_q;
  assign s_r_o.resp   = RESP_OKAY;

endmodule

// ==== rtl/l1_cfg_regfile.sv ====
/* L1 slice configuration slots, masked by slot kind on every write.
   Range checks are left to the bus port; slots 0..3 are therefore never written. */

`timescale 1ns/1ns

module l1_cfg_regfile #(
  parameter int unsigned N_REGS = 196
) (
  input  logic                                            Clk_CI,
  input  logic                                            Rst_RBI,
  input  logic                                            wr_i,
  input  logic                                            sel_i,
  input  rab_cfg_pkg::cfg_addr_u                          wr_addr_i,
  input  rab_axi_pkg::axi_w_t                             wr_data_i,
  input  rab_cfg_pkg::cfg_addr_u                          rd_addr_i,
  output logic [rab_axi_pkg::AXI_DATA_W-1:0]              rdata_o,
  output logic [N_REGS-1:0][rab_axi_pkg::AXI_DATA_W-1:0]  l1_cfg_o
);
  import rab_axi_pkg::*;
  import rab_cfg_pkg::*;

  function automatic logic [AXI_DATA_W-1:0] kind_mask(input slot_kind_e kind);
    case (kind)
      SLOT_PHYS:  return AXI_DATA_W'({PHYS_ADDR_W{1'b1}});
      SLOT_FLAGS: return AXI_DATA_W'({N_FLAGS{1'b1}});
      default:    return AXI_DATA_W'({VIRT_ADDR_W{1'b1}});
    endcase
  endfunction

  logic wr_en;

  assign wr_en = wr_i & sel_i;

  for (genvar i = 0; i < N_REGS; i++)
  begin : g_slot
    localparam logic [AXI_DATA_W-1:0] MASK = kind_mask(slot_kind_of(2'(i)));

    logic [AXI_DATA_W-1:0] slot_q;

    always_ff @(posedge Clk_CI or negedge Rst_RBI)
    begin
      if (!Rst_RBI)
        slot_q <= '0;
      else if (wr_en && (wr_addr_i.l1.slot == SLOT_IDX_W'(i)))
      begin
        for (int b = 0; b < AXI_STRB_W; b++)
        begin
          // masked bits stay zero, so unused flops are constant
          if (wr_data_i.strb[b])
            slot_q[8*b +: 8] <= wr_data_i.data[8*b +: 8] & MASK[8*b +: 8];
        end
      end
    end

    assign l1_cfg_o[i] = slot_q;
  end

  // guard against slot indices beyond the array
  assign rdata_o = (rd_addr_i.l1.slot < N_REGS) ? l1_cfg_o[rd_addr_i.l1.slot] : '0;

endmodule

// ==== rtl/miss_fifo_unit.sv ====
/* Miss queue and miss handling control register.
   A miss arriving while the queue is full is dropped and flagged for that cycle only. */

`timescale 1ns/1ns

module miss_fifo_unit #(
  parameter int unsigned MH_FIFO_DEPTH = 16
) (
  input  logic                               Clk_CI,
  input  logic                               Rst_RBI,
  input  logic                               wr_i,
  input  logic                               sel_i,
  input  rab_cfg_pkg::cfg_addr_u             wr_addr_i,
  input  rab_axi_pkg::axi_w_t                wr_data_i,
  input  rab_cfg_pkg::cfg_addr_u             rd_addr_i,
  input  logic                               pop_i,
  output logic [rab_axi_pkg::AXI_DATA_W-1:0] rdata_o,
  input  logic                               miss_i,
  input  rab_cfg_pkg::miss_entry_t           miss_entry_i,
  output logic                               mh_fifo_full_o,
  output logic                               allow_multi_hit_o
);
  import rab_axi_pkg::*;
  import rab_cfg_pkg::*;

  localparam int unsigned PTR_W = (MH_FIFO_DEPTH > 1) ? $clog2(MH_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(MH_FIFO_DEPTH + 1);

  miss_entry_t      mem_q [MH_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  mh_ctrl_t         ctrl_q;
  miss_entry_t      head;

  logic empty;
  logic full;
  logic push;
  logic pop;
  logic miss_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(MH_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (cnt_q == '0);
  assign full    = (cnt_q == CNT_W'(MH_FIFO_DEPTH));
  assign miss_en = miss_i & ~ctrl_q.fifo_disable;
  assign push    = miss_en & ~full;
  assign pop     = pop_i & ~empty;
  assign head    = mem_q[rd_ptr_q];

  assign mh_fifo_full_o    = miss_en & full;
  assign allow_multi_hit_o = ctrl_q.allow_multi_hit;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (push)
      mem_q[wr_ptr_q] <= miss_entry_i;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      ctrl_q <= '0;
    else if (wr_i && sel_i && (wr_addr_i.mh.ofs == MH_CTRL_OFS))
      ctrl_q <= mh_ctrl_t'(wr_data_i.data[1:0]);
  end

  always_comb
  begin
    rdata_o = '0;
    case (rd_addr_i.mh.ofs)
      MH_ADDR_OFS:
      begin
        if (!empty)
          rdata_o = AXI_DATA_W'(head.addr);
      end
      MH_META_OFS:
      begin
        if (!empty)
          rdata_o[MISS_META_W-1:0] = head.meta;
        rdata_o[MH_EMPTY_BIT] = empty;
      end
      MH_CTRL_OFS: rdata_o = AXI_DATA_W'(ctrl_q);
      default:     rdata_o = '0; // write-only or unused offsets
    endcase
  end

endmodule

// ==== rtl/rab_cfg_top.sv ====
/* RAB configuration block: AXI4-Lite port, L1 slice registers and miss queue.
   N_REGS may not exceed 256, the reach of the slot index field. */

`timescale 1ns/1ns

module rab_cfg_top #(
  parameter int unsigned N_REGS        = 196,
  parameter int unsigned MH_FIFO_DEPTH = 16
) (
  input  logic                                            Clk_CI,
  input  logic                                            Rst_RBI,
  input  rab_axi_pkg::axi_aw_t                            s_aw_i,
  input  logic                                            s_awvalid_i,
  output logic                                            s_awready_o,
  input  rab_axi_pkg::axi_w_t                             s_w_i,
  input  logic                                            s_wvalid_i,
  output logic                                            s_wready_o,
  output rab_axi_pkg::axi_b_t                             s_b_o,
  output logic                                            s_bvalid_o,
  input  logic                                            s_bready_i,
  input  rab_axi_pkg::axi_aw_t                            s_ar_i,
  input  logic                                            s_arvalid_i,
  output logic                                            s_arready_o,
  output rab_axi_pkg::axi_r_t                             s_r_o,
  output logic                                            s_rvalid_o,
  input  logic                                            s_rready_i,
  output logic [N_REGS-1:0][rab_axi_pkg::AXI_DATA_W-1:0]  l1_cfg_o,
  output logic                                            allow_multi_hit_o,
  input  logic                                            miss_i,
  input  rab_cfg_pkg::miss_entry_t                        miss_entry_i,
  output logic                                            mh_fifo_full_o
);
  import rab_axi_pkg::*;
  import rab_cfg_pkg::*;

  logic                  wr;
  logic                  l1_sel;
  logic                  mh_sel;
  cfg_addr_u             wr_addr;
  axi_w_t                wr_data;
  cfg_addr_u             rd_addr;
  logic                  rd_pop;
  logic [AXI_DATA_W-1:0] l1_rdata;
  logic [AXI_DATA_W-1:0] mh_rdata;

  axi_lite_cfg_port #(
    .N_REGS (N_REGS)
  ) u_port (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .s_aw_i      (s_aw_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_w_i       (s_w_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_b_o       (s_b_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_ar_i      (s_ar_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_r_o       (s_r_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .wr_o        (wr),
    .l1_sel_o    (l1_sel),
    .mh_sel_o    (mh_sel),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .rd_addr_o   (rd_addr),
    .rd_pop_o    (rd_pop),
    .l1_rdata_i  (l1_rdata),
    .mh_rdata_i  (mh_rdata)
  );

  l1_cfg_regfile #(
    .N_REGS (N_REGS)
  ) u_l1_regfile (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .wr_i      (wr),
    .sel_i     (l1_sel),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rdata_o   (l1_rdata),
    .l1_cfg_o  (l1_cfg_o)
  );

  miss_fifo_unit #(
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) u_miss_unit (
    .Clk_CI            (Clk_CI),
    .Rst_RBI           (Rst_RBI),
    .wr_i              (wr),
    .sel_i             (mh_sel),
    .wr_addr_i         (wr_addr),
    .wr_data_i         (wr_data),
    .rd_addr_i         (rd_addr),
    .pop_i             (rd_pop),
    .rdata_o           (mh_rdata),
    .miss_i            (miss_i),
    .miss_entry_i      (miss_entry_i),
    .mh_fifo_full_o    (mh_fifo_full_o),
    .allow_multi_hit_o (allow_multi_hit_o)
  );

endmodule

// ==== testbench/rab_cfg_properties.sv ====
/* AXI4-Lite response rules of the configuration port, checked out of reset only. */

`timescale 1ns/1ns

module rab_cfg_properties (
  input logic                Clk_CI,
  input logic                Rst_RBI,
  input logic                bvalid_i,
  input logic                bready_i,
  input logic                rvalid_i,
  input logic                rready_i,
  input rab_axi_pkg::axi_r_t r_i,
  input logic                wr_i
);

  int fail_cnt = 0;

  a_bvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i && !bready_i |=> bvalid_i)
  else
  begin
    fail_cnt++;
    $error("bvalid dropped before bready");
  end

  // stalled read beat keeps its data
  a_rdata_stable: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_i && !rready_i |=> rvalid_i && $stable(r_i.data))
  else
  begin
    fail_cnt++;
    $error("rdata or rvalid changed while rready was low");
  end

  a_wr_single: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_i |=> !wr_i)
  else
  begin
    fail_cnt++;
    $error("write strobe high on two consecutive cycles");
  end

endmodule

// ==== testbench/tb_rab_cfg.sv ====
/* Trace-driven testbench of the RAB configuration block.
   The trace path is relative to the project root, so run the simulator from there. */

`timescale 1ns/1ns

module tb_rab_cfg;
  import rab_axi_pkg::*;
  import rab_cfg_pkg::*;

  localparam int unsigned N_REGS        = 196;
  localparam int unsigned MH_FIFO_DEPTH = 16;
  localparam time         T_CLK         = 100ns;
  localparam time         T_DRV         = 10ns; // input skew after the rising edge
  localparam int          RST_CYCLES    = 8;
  localparam int          CYC_PER_OP    = 40;
  localparam string       TRACE_FILE    = "testbench/rab_cfg_trace.txt";

  logic                              Clk_CI;
  logic                              Rst_RBI;
  axi_aw_t                           s_aw;
  logic                              s_awvalid;
  logic                              s_awready;
  axi_w_t                            s_w;
  logic                              s_wvalid;
  logic                              s_wready;
  axi_b_t                            s_b;
  logic                              s_bvalid;
  logic                              s_bready;
  axi_aw_t                           s_ar;
  logic                              s_arvalid;
  logic                              s_arready;
  axi_r_t                            s_r;
  logic                              s_rvalid;
  logic                              s_rready;
  logic [N_REGS-1:0][AXI_DATA_W-1:0] l1_cfg;
  logic                              allow_multi_hit;
  logic                              miss;
  miss_entry_t                       miss_entry;
  logic                              mh_fifo_full;

  logic [31:0] lcg_state   = 32'h557a;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          value_errs  = 0;
  int          other_errs  = 0;

  // parsed trace with one entry per line
  byte         op_q[$];
  logic [31:0] addr_q[$];
  logic [63:0] data_q[$];
  logic [7:0]  strb_q[$];
  logic [63:0] exp_q[$];

  rab_cfg_top #(
    .N_REGS        (N_REGS),
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) u_rab_cfg_top (
    .Clk_CI            (Clk_CI),
    .Rst_RBI           (Rst_RBI),
    .s_aw_i            (s_aw),
    .s_awvalid_i       (s_awvalid),
    .s_awready_o       (s_awready),
    .s_w_i             (s_w),
    .s_wvalid_i        (s_wvalid),
    .s_wready_o        (s_wready),
    .s_b_o             (s_b),
    .s_bvalid_o        (s_bvalid),
    .s_bready_i        (s_bready),
    .s_ar_i            (s_ar),
    .s_arvalid_i       (s_arvalid),
    .s_arready_o       (s_arready),
    .s_r_o             (s_r),
    .s_rvalid_o        (s_rvalid),
    .s_rready_i        (s_rready),
    .l1_cfg_o          (l1_cfg),
    .allow_multi_hit_o (allow_multi_hit),
    .miss_i            (miss),
    .miss_entry_i      (miss_entry),
    .mh_fifo_full_o    (mh_fifo_full)
  );

  bind axi_lite_cfg_port rab_cfg_properties u_props (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .bvalid_i (s_bvalid_o),
    .bready_i (s_bready_i),
    .rvalid_i (s_rvalid_o),
    .rready_i (s_rready_i),
    .r_i      (s_r_o),
    .wr_i     (wr_o)
  );

  initial Clk_CI = 1'b0;

  always #(T_CLK/2) Clk_CI = ~Clk_CI;

  // stall of 0 to 3 cycles from the upper LCG bits
  function automatic int rand_stall();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[31:30]);
  endfunction

  task automatic next_cycle();
    @(posedge Clk_CI);
    #T_DRV;
  endtask

  task automatic compare_word(input string name, input logic [63:0] got,
                              input logic [63:0] exp_val);
    assert (got === exp_val)
    else
    begin
      value_errs++;
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp_val);
    end
  endtask

  task automatic report_counts();
    $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
             value_errs, other_errs, u_rab_cfg_top.u_port.u_props.fail_cnt);
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    logic aw_pend;
    logic w_pend;
    logic b_seen;
    int   stall;

    aw_pend   = 1'b1;
    w_pend    = 1'b1;
    b_seen    = 1'b0;
    stall     = rand_stall();
    s_aw.addr = addr;
    s_w.data  = data;
    s_w.strb  = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    while (aw_pend || w_pend)
    begin
      @(negedge Clk_CI); // decide the handshake on settled values
      if (s_awvalid && s_awready)
        aw_pend = 1'b0;
      if (s_wvalid && s_wready)
        w_pend = 1'b0;
      next_cycle();
      s_awvalid = aw_pend;
      s_wvalid  = w_pend;
    end
    s_bready = (stall == 0);
    do
    begin
      @(negedge Clk_CI);
      if (s_bvalid)
      begin
        b_seen = 1'b1;
        compare_word("s_b_o.resp", 64'(s_b.resp), 64'(RESP_OKAY));
      end
      next_cycle();
    end
    while (!b_seen);
    if (stall > 0)
    begin
      repeat (stall - 1)
        next_cycle();
      s_bready = 1'b1;
      next_cycle();
    end
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [63:0] data);
    logic ar_pend;
    logic r_seen;
    int   stall;

    ar_pend   = 1'b1;
    r_seen    = 1'b0;
    data      = '0;
    stall     = rand_stall();
    s_ar.addr = addr;
    s_arvalid = 1'b1;
    while (ar_pend)
    begin
      @(negedge Clk_CI);
      if (s_arvalid && s_arready)
        ar_pend = 1'b0;
      next_cycle();
      s_arvalid = ar_pend;
    end
    s_rready = (stall == 0);
    do
    begin
      @(negedge Clk_CI);
      if (s_rvalid)
      begin
        r_seen = 1'b1;
        data   = s_r.data; // held by the DUT until rready
        compare_word("s_r_o.resp", 64'(s_r.resp), 64'(RESP_OKAY));
      end
      next_cycle();
    end
    while (!r_seen);
    if (stall > 0)
    begin
      repeat (stall - 1)
        next_cycle();
      s_rready = 1'b1;
      next_cycle();
    end
    s_rready = 1'b0;
  endtask

  // back-to-back misses with the address stepping by 4 KiB and meta by one
  task automatic send_miss(input logic [31:0] addr, input logic [63:0] meta,
                           input int count, input logic check_full, input logic exp_full);
    for (int k = 0; k < count; k++)
    begin
      miss            = 1'b1;
      miss_entry.addr = addr + 32'(k) * 32'h1000;
      miss_entry.meta = meta[MISS_META_W-1:0] + MISS_META_W'(k);
      @(negedge Clk_CI);
      if (check_full)
        compare_word("mh_fifo_full_o", 64'(mh_fifo_full), 64'(exp_full));
      next_cycle();
    end
    miss = 1'b0;
  endtask

  always @(posedge Clk_CI)
  begin
    cycle_cnt++;
    if ((cycle_limit > 0) && (cycle_cnt > cycle_limit))
    begin
      other_errs++;
      $display("timeout: trace not finished after %0d cycles", cycle_limit);
      report_counts();
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    int          fd;
    int          n;
    int          slot;
    string       line;
    byte         op;
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;
    logic [63:0] exp_val;
    logic [63:0] rd;

    Rst_RBI    = 1'b0;
    s_aw       = '0;
    s_awvalid  = 1'b0;
    s_w        = '0;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_ar       = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    miss       = 1'b0;
    miss_entry = '0;

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      other_errs++;
      $display("could not open trace file %s", TRACE_FILE);
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n    = $fgets(line, fd);
        if ((n == 0) || (line[0] == "#") || (line[0] == "\n"))
          continue;
        n = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, exp_val);
        if (n == 5)
        begin
          op_q.push_back(op);
          addr_q.push_back(addr);
          data_q.push_back(data);
          strb_q.push_back(strb);
          exp_q.push_back(exp_val);
        end
        else
        begin
          other_errs++;
          $display("malformed trace line: %s", line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = RST_CYCLES + CYC_PER_OP * (op_q.size() + 1);

    repeat (RST_CYCLES)
      @(posedge Clk_CI);
    #T_DRV;
    Rst_RBI = 1'b1;
    next_cycle();

    foreach (op_q[i])
    begin
      case (op_q[i])
        "W": axi_write(addr_q[i], data_q[i], strb_q[i]);
        "R":
        begin
          axi_read(addr_q[i], rd);
          compare_word($sformatf("s_r_o.data (addr 0x%h)", addr_q[i]), rd, exp_q[i]);
          // an L1 slot shows the same masked word on the slice output
          if ((addr_q[i] >= CFG_SPACE_SIZE) && (addr_q[i] < N_REGS * AXI_STRB_W))
          begin
            slot = int'(addr_q[i] / AXI_STRB_W);
            compare_word($sformatf("l1_cfg_o[%0d]", slot), l1_cfg[slot], exp_q[i]);
          end
        end
        "M": send_miss(addr_q[i], data_q[i], int'(strb_q[i]), 1'b0, 1'b0);
        "F": send_miss(addr_q[i], data_q[i], int'(strb_q[i]), 1'b1, exp_q[i][0]);
        "A":
        begin
          @(negedge Clk_CI);
          compare_word("allow_multi_hit_o", 64'(allow_multi_hit), exp_q[i]);
          next_cycle();
        end
        default:
        begin
          other_errs++;
          $display("unknown trace operation '%c' in entry %0d", op_q[i], i);
        end
      endcase
    end

    next_cycle();
    report_counts();
    if ((value_errs == 0) && (other_errs == 0) && (u_rab_cfg_top.u_port.u_props.fail_cnt == 0))
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== testbench/rab_cfg_trace.txt ====
# op addr data strb expect, all hex; W write, R read and compare, A compare allow_multi_hit_o
# M and F send misses: addr and data give address and meta, strb the repeat count, F checks full
R 00000020 0000000000000000 00 0000000000000000
R 00000038 0000000000000000 00 0000000000000000
R 0000000C 0000000000000000 00 0000000000000000
R 00000008 0000000000000000 00 0000000080000000
W 00000020 FFFFFFFFFFFFFFFF FF 0000000000000000
W 00000030 FFFFFFFFFFFFFFFF FF 0000000000000000
W 00000038 FFFFFFFFFFFFFFFF FF 0000000000000000
W 00000618 FFFFFFFFFFFFFFFF FF 0000000000000000
R 00000020 0000000000000000 00 00000000FFFFFFFF
R 00000030 0000000000000000 00 000000FFFFFFFFFF
R 00000038 0000000000000000 00 000000000000000F
R 00000618 0000000000000000 00 000000000000000F
W 00000028 1122334455667788 0A 0000000000000000
R 00000028 0000000000000000 00 0000000055007700
W 00000030 AABBCCDDEEFF0011 30 0000000000000000
R 00000030 0000000000000000 00 000000DDFFFFFFFF
M 12345000 00000000000003A5 01 0000000000000000
M 0ABCD000 00000000000000F0 01 0000000000000000
R 00000000 0000000000000000 00 0000000012345000
R 00000008 0000000000000000 00 00000000000003A5
R 00000000 0000000000000000 00 000000000ABCD000
R 00000008 0000000000000000 00 00000000000000F0
R 00000008 0000000000000000 00 0000000080000000
M 00100000 0000000000000001 10 0000000000000000
F 00FF0000 00000000000003FF 01 0000000000000001
R 00000000 0000000000000000 00 0000000000100000
W 0000000C 0000000000000003 FF 0000000000000000
A 00000000 0000000000000000 00 0000000000000001
R 0000000C 0000000000000000 00 0000000000000003
F 00EE0000 00000000000003FF 01 0000000000000000
R 00000008 0000000000000000 00 0000000000000001
R 00000000 0000000000000000 00 0000000000101000
W 0000000C 0000000000000002 FF 0000000000000000
R 0000000C 0000000000000000 00 0000000000000002
A 00000000 0000000000000000 00 0000000000000001
F 00DD0000 00000000000003FF 01 0000000000000000
F 00CC0000 00000000000003FF 01 0000000000000001

// ==== tb.f ====
rtl/rab_axi_pkg.sv
rtl/rab_cfg_pkg.sv
rtl/axi_lite_cfg_port.sv
rtl/l1_cfg_regfile.sv
rtl/miss_fifo_unit.sv
rtl/rab_cfg_top.sv
testbench/rab_cfg_properties.sv
testbench/tb_rab_cfg.sv

// ==== Bender.yml ====
package:
  name: rab_cfg

sources:
  - rtl/rab_axi_pkg.sv
  - rtl/rab_cfg_pkg.sv
  - rtl/axi_lite_cfg_port.sv
  - rtl/l1_cfg_regfile.sv
  - rtl/miss_fifo_unit.sv
  - rtl/rab_cfg_top.sv
  - target: test
    files:
      - testbench/rab_cfg_properties.sv
      - testbench/tb_rab_cfg.sv

export_include_dirs: []

dependencies: {}
